// ==== alu_cfg_pkg.sv ====
`default_nettype none

package alu_cfg_pkg;

    // quotient bits per divider cycle, legal values 1, 2 and 4
    localparam int default_div_bits = 1;

    // cycles from accept to done for a given step width
    function automatic int div_cycles(input int bits);
        return riscv_isa_pkg::word_len / bits;
    endfunction

    // counter width able to hold the full cycle count
    function automatic int div_cnt_width(input int bits);
        return $clog2(div_cycles(bits) + 1);
    endfunction

endpackage

`default_nettype wire

// ==== alu_issue.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_issue (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  order,
    output logic                  accepted,
    output logic                  done,
    input  riscv_isa_pkg::func3_t func3,
    input  logic                  extension_flag,
    input  riscv_isa_pkg::word_t  int_result,
    output logic                  div_start,
    output logic                  div_signed,
    output logic                  div_rem,
    input  logic                  div_done,
    input  riscv_isa_pkg::word_t  div_result,
    output riscv_isa_pkg::word_t  rd
);

    import riscv_isa_pkg::*;

    logic  busy;
    logic  is_div;
    logic  now_done;
    word_t fin_result;
    word_t rd_hold;

    assign is_div = extension_flag &&
                    (func3 == func3_div || func3 == func3_divu ||
                     func3 == func3_rem || func3 == func3_remu);

    // a divide in flight blocks new orders
    assign accepted = order && !busy;

    assign div_start  = accepted && is_div;
    assign div_signed = (func3 == func3_div) || (func3 == func3_rem);
    assign div_rem    = (func3 == func3_rem) || (func3 == func3_remu);

    // everything but a divide finishes in the order cycle
    assign now_done = accepted && !is_div;
    assign done     = now_done || div_done;

    always_comb begin
        if (div_done) begin
            fin_result = div_result;
        end else if (extension_flag) begin
            // multiply codes return zero
            fin_result = '0;
        end else begin
            fin_result = int_result;
        end
    end

    assign rd = done ? fin_result : rd_hold;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy <= 1'b0;
        end else if (div_start) begin
            busy <= 1'b1;
        end else if (div_done) begin
            busy <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_hold <= '0;
        end else if (done) begin
            rd_hold <= fin_result;
        end
    end

endmodule

`default_nettype wire

// ==== alu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_top #(
    parameter int div_bits = alu_cfg_pkg::default_div_bits
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  order,
    output logic                  accepted,
    output logic                  done,
    input  riscv_isa_pkg::func3_t func3,
    input  logic                  mode_flag,
    input  logic                  imm_flag,
    input  logic                  extension_flag,
    input  riscv_isa_pkg::word_t  rs1,
    input  riscv_isa_pkg::word_t  rs2,
    output riscv_isa_pkg::word_t  rd
);

    import riscv_isa_pkg::*;

    word_t int_result;
    word_t div_result;
    logic  div_start;
    logic  div_signed;
    logic  div_rem;
    logic  div_done;

    alu_issue u_issue (
        .clk            (clk),
        .arst_n         (arst_n),
        .order          (order),
        .accepted       (accepted),
        .done           (done),
        .func3          (func3),
        .extension_flag (extension_flag),
        .int_result     (int_result),
        .div_start      (div_start),
        .div_signed     (div_signed),
        .div_rem        (div_rem),
        .div_done       (div_done),
        .div_result     (div_result),
        .rd             (rd)
    );

    int_unit u_int (
        .func3     (func3),
        .mode_flag (mode_flag),
        .imm_flag  (imm_flag),
        .rs1       (rs1),
        .rs2       (rs2),
        .result    (int_result)
    );

    div_unit #(
        .div_bits (div_bits)
    ) u_div (
        .clk       (clk),
        .arst_n    (arst_n),
        .start     (div_start),
        .is_signed (div_signed),
        .want_rem  (div_rem),
        .dividend  (rs1),
        .divisor   (rs2),
        .done      (div_done),
        .result    (div_result)
    );

endmodule

`default_nettype wire

// ==== div_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module div_unit #(
    parameter int div_bits = alu_cfg_pkg::default_div_bits
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 start,
    input  logic                 is_signed,
    input  logic                 want_rem,
    input  riscv_isa_pkg::word_t dividend,
    input  riscv_isa_pkg::word_t divisor,
    output logic                 done,
    output riscv_isa_pkg::word_t result
);

    import riscv_isa_pkg::*;
    import alu_cfg_pkg::*;

    localparam int steps = div_cycles(div_bits);
    localparam int cnt_w = div_cnt_width(div_bits);

    logic             running;
    logic [cnt_w-1:0] count;

    // partial remainder, dividend/quotient shift register, divisor
    word_t rem_q;
    word_t quo_q;
    word_t dvs_q;
    logic  neg_quo;
    logic  neg_rem;
    logic  rem_sel;

    word_t dividend_mag;
    word_t divisor_mag;
    word_t rem_nxt;
    word_t quo_nxt;
    word_t quo_fix;
    word_t rem_fix;

    assign dividend_mag = (is_signed && dividend[word_len-1]) ? -dividend : dividend;
    assign divisor_mag  = (is_signed && divisor[word_len-1])  ? -divisor  : divisor;

    // restoring steps, div_bits of them per cycle
    always_comb begin
        logic [word_len:0] trial;

        rem_nxt = rem_q;
        quo_nxt = quo_q;
        for (int i = 0; i < div_bits; i++) begin
            trial   = {rem_nxt, quo_nxt[word_len-1]};
            quo_nxt = quo_nxt << 1;
            if (trial >= {1'b0, dvs_q}) begin
                trial      = trial - {1'b0, dvs_q};
                quo_nxt[0] = 1'b1;
            end
            rem_nxt = trial[word_len-1:0];
        end
    end

    // last step is taken combinationally in the done cycle
    assign done = running && (count == cnt_w'(1));

    assign quo_fix = neg_quo ? -quo_nxt : quo_nxt;
    assign rem_fix = neg_rem ? -rem_nxt : rem_nxt;
    assign result  = rem_sel ? rem_fix : quo_fix;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            running <= 1'b0;
            count   <= '0;
        end else if (start) begin
            running <= 1'b1;
            count   <= cnt_w'(steps);
        end else if (running) begin
            count <= count - cnt_w'(1);
            if (count == cnt_w'(1)) begin
                running <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            rem_q   <= '0;
            quo_q   <= dividend_mag;
            dvs_q   <= divisor_mag;
            // divide by zero keeps the all ones quotient unsigned
            neg_quo <= is_signed && (dividend[word_len-1] ^ divisor[word_len-1]) &&
                       (divisor != '0);
            // remainder takes the sign of the dividend
            neg_rem <= is_signed && dividend[word_len-1];
            rem_sel <= want_rem;
        end else if (running) begin
            rem_q <= rem_nxt;
            quo_q <= quo_nxt;
        end
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
riscv_isa_pkg.sv
alu_cfg_pkg.sv
int_unit.sv
div_unit.sv
alu_issue.sv
alu_top.sv
tb_alu.sv

// ==== int_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module int_unit (
    input  riscv_isa_pkg::func3_t func3,
    input  logic                  mode_flag,
    input  logic                  imm_flag,
    input  riscv_isa_pkg::word_t  rs1,
    input  riscv_isa_pkg::word_t  rs2,
    output riscv_isa_pkg::word_t  result
);

    import riscv_isa_pkg::*;

    logic [shamt_len-1:0] shamt;
    logic                 do_sub;
    word_t                add_res;
    word_t                sll_res;
    word_t                srl_res;
    word_t                sra_res;
    word_t                xor_res;
    word_t                or_res;
    word_t                and_res;

    assign shamt = rs2[shamt_len-1:0];

    // addi has no sub form, bit 5 there belongs to the immediate
    assign do_sub = mode_flag && !imm_flag;

    assign add_res = do_sub ? (rs1 - rs2) : (rs1 + rs2);

    assign sll_res = rs1 << shamt;
    assign srl_res = rs1 >> shamt;
    assign sra_res = word_t'($signed(rs1) >>> shamt);

    assign xor_res = rs1 ^ rs2;
    assign or_res  = rs1 | rs2;
    assign and_res = rs1 & rs2;

    always_comb begin
        case (func3)
            func3_add: begin
                result = add_res;
            end
            func3_sl: begin
                result = sll_res;
            end
            func3_xor: begin
                result = xor_res;
            end
            func3_sr: begin
                result = mode_flag ? sra_res : srl_res;
            end
            func3_or: begin
                result = or_res;
            end
            func3_and: begin
                result = and_res;
            end
            // slt and sltu are not implemented
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== riscv_isa_pkg.sv ====
`default_nettype none

package riscv_isa_pkg;

    // RV32 data path
    localparam int word_len = 32;
    typedef logic [word_len-1:0] word_t;

    // low bits of rs2 or the immediate give the shift amount
    localparam int shamt_len = 5;

    typedef logic [2:0] func3_t;

    // flags that come with each order, taken from the opcode and func7:
    //   mode_flag      funct7 bit 5, selects sub and sra
    //   imm_flag       immediate form, where bit 5 is part of the immediate
    //   extension_flag M extension (funct7 = 0000001)

    // base integer ops, extension_flag clear
    localparam func3_t func3_add = 3'b000;
    localparam func3_t func3_sl  = 3'b001;
    localparam func3_t func3_xor = 3'b100;
    localparam func3_t func3_sr  = 3'b101;
    localparam func3_t func3_or  = 3'b110;
    localparam func3_t func3_and = 3'b111;

    // M extension divide ops, extension_flag set
    // codes 000 to 011 are the multiplies
    localparam func3_t func3_div  = 3'b100;
    localparam func3_t func3_divu = 3'b101;
    localparam func3_t func3_rem  = 3'b110;
    localparam func3_t func3_remu = 3'b111;

endpackage

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build and run the ALU testbench with Verilator, result taken from sim.log

cd "$(dirname "$0")" || exit 1

rm -f sim.log

verilator --binary --timing -f filelist.f --top-module tb_alu -o tb_alu_sim > build.log 2>&1 \
    && ./obj_dir/tb_alu_sim > sim.log 2>&1 \
    || { echo "build or simulation did not complete, see build.log and sim.log"; exit 1; }

cat sim.log

grep -q "TEST RESULT: FAIL" sim.log && { echo "simulation failed"; exit 1; } \
    || { echo "simulation passed"; exit 0; }

// ==== tb_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_alu;

    import riscv_isa_pkg::*;

    localparam int div_bits    = 1;
    localparam int clk_period  = 40;
    localparam int div_latency = word_len / div_bits;

    logic   clk;
    logic   arst_n;
    logic   order;
    logic   accepted;
    logic   done;
    func3_t func3;
    logic   mode_flag;
    logic   imm_flag;
    logic   extension_flag;
    word_t  rs1;
    word_t  rs2;
    word_t  rd;

    // one entry per vector line, [0] func3 up to [6] expected rd
    logic [6:0][31:0] vecs[$];

    int n_tests;
    int n_failed;
    int n_errs;
    bit loaded;

    alu_top #(
        .div_bits (div_bits)
    ) dut0 (
        .clk            (clk),
        .arst_n         (arst_n),
        .order          (order),
        .accepted       (accepted),
        .done           (done),
        .func3          (func3),
        .mode_flag      (mode_flag),
        .imm_flag       (imm_flag),
        .extension_flag (extension_flag),
        .rs1            (rs1),
        .rs2            (rs2),
        .rd             (rd)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic check(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("FAIL %s got %h expected %h", name, got, exp);
            n_errs++;
        end
    endtask

    function automatic string op_name(input func3_t f3, input logic ext, input logic mode,
                                      input logic imm);
        if (ext) begin
            case (f3)
                func3_div:  return "div";
                func3_divu: return "divu";
                func3_rem:  return "rem";
                func3_remu: return "remu";
                default:    return "mul code";
            endcase
        end
        case (f3)
            func3_add: return (mode && !imm) ? "sub" : "add";
            func3_sl:  return "sll";
            func3_xor: return "xor";
            func3_sr:  return mode ? "sra" : "srl";
            func3_or:  return "or";
            func3_and: return "and";
            default:   return "other";
        endcase
    endfunction

    task automatic finish_test(input string tag, input int errs_before);
        n_tests++;
        if (n_errs == errs_before) begin
            $display("test %0d %s ok", n_tests, tag);
        end else begin
            n_failed++;
            $display("test %0d %s failed", n_tests, tag);
        end
    endtask

    task automatic run_op(input string tag, input func3_t f3, input logic mode, input logic imm,
                          input logic ext, input word_t a, input word_t b, input word_t exp);
        int   errs_before;
        int   cycles;
        logic is_div;

        errs_before = n_errs;
        // divide codes are func3 1xx with the extension flag
        is_div = ext && f3[2];
        @(negedge clk);
        order          = 1'b1;
        func3          = f3;
        mode_flag      = mode;
        imm_flag       = imm;
        extension_flag = ext;
        rs1            = a;
        rs2            = b;
        #10;
        check("accepted", 32'(accepted), 32'd1);
        if (!is_div) begin
            check("done", 32'(done), 32'd1);
            check("rd", rd, exp);
        end else begin
            check("done", 32'(done), 32'd0);
            @(negedge clk);
            // operands must already be captured
            order = 1'b0;
            rs1   = $urandom;
            rs2   = $urandom;
            #10;
            cycles = 1;
            while (!done) begin
                @(negedge clk);
                #10;
                cycles++;
            end
            check("latency", 32'(cycles), 32'(div_latency));
            check("rd", rd, exp);
        end
        // idle cycle, rd holds
        @(negedge clk);
        order = 1'b0;
        rs1   = $urandom;
        rs2   = $urandom;
        #10;
        check("done", 32'(done), 32'd0);
        check("rd", rd, exp);
        finish_test(tag, errs_before);
    endtask

    task automatic held_order_test;
        int    errs_before;
        int    cycles;
        word_t add_a;
        word_t add_b;

        errs_before = n_errs;
        add_a       = 32'h12345678;
        add_b       = 32'h11111111;
        @(negedge clk);
        order          = 1'b1;
        func3          = func3_divu;
        mode_flag      = 1'b0;
        imm_flag       = 1'b0;
        extension_flag = 1'b1;
        rs1            = 32'd1000;
        rs2            = 32'd7;
        #10;
        check("accepted", 32'(accepted), 32'd1);
        check("done", 32'(done), 32'd0);
        // next order follows at once and stays up
        @(negedge clk);
        func3          = func3_add;
        extension_flag = 1'b0;
        rs1            = add_a;
        rs2            = add_b;
        #10;
        cycles = 1;
        while (!done) begin
            check("accepted", 32'(accepted), 32'd0);
            @(negedge clk);
            #10;
            cycles++;
        end
        check("latency", 32'(cycles), 32'(div_latency));
        check("accepted", 32'(accepted), 32'd0);
        check("rd", rd, 32'd142);
        @(negedge clk);
        #10;
        check("accepted", 32'(accepted), 32'd1);
        check("done", 32'(done), 32'd1);
        check("rd", rd, add_a + add_b);
        @(negedge clk);
        order = 1'b0;
        #10;
        check("rd", rd, add_a + add_b);
        finish_test("held order", errs_before);
    endtask

    initial begin
        int          fd;
        int          code;
        int          op;
        string       line;
        word_t       c_f3;
        word_t       c_mode;
        word_t       c_imm;
        word_t       c_ext;
        word_t       c_a;
        word_t       c_b;
        word_t       c_exp;
        func3_t      f3;
        int          errs_before;

        void'($urandom(95));
        n_tests        = 0;
        n_failed       = 0;
        n_errs         = 0;
        arst_n         = 1'b0;
        order          = 1'b0;
        func3          = '0;
        mode_flag      = 1'b0;
        imm_flag       = 1'b0;
        extension_flag = 1'b0;
        rs1            = '0;
        rs2            = '0;

        fd = $fopen("tb_alu_input.txt", "r");
        if (fd == 0) begin
            $display("could not open the vector file tb_alu_input.txt");
            n_errs++;
        end else begin
            while (!$feof(fd)) begin
                code = $fgets(line, fd);
                if (code > 0 && line.len() > 1 && line[0] != 8'h2f) begin
                    if ($sscanf(line, "%h %h %h %h %h %h %h", c_f3, c_mode, c_imm, c_ext,
                                c_a, c_b, c_exp) == 7) begin
                        vecs.push_back({c_exp, c_b, c_a, c_ext, c_imm, c_mode, c_f3});
                    end
                end
            end
            $fclose(fd);
            if (vecs.size() == 0) begin
                $display("no test vectors were read from tb_alu_input.txt");
                n_errs++;
            end
        end
        loaded = 1'b1;

        repeat (4) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        errs_before = n_errs;
        #10;
        check("accepted", 32'(accepted), 32'd0);
        check("done", 32'(done), 32'd0);
        check("rd", rd, 32'd0);
        finish_test("after reset", errs_before);

        foreach (vecs[i]) begin
            run_op(op_name(vecs[i][0][2:0], vecs[i][3][0], vecs[i][1][0], vecs[i][2][0]),
                   vecs[i][0][2:0], vecs[i][1][0], vecs[i][2][0], vecs[i][3][0],
                   vecs[i][4], vecs[i][5], vecs[i][6]);
        end

        held_order_test();

        // random logic ops
        for (int i = 0; i < 20; i++) begin
            op    = int'($urandom % 3);
            c_a   = $urandom;
            c_b   = $urandom;
            if (op == 0) begin
                f3    = func3_and;
                c_exp = c_a & c_b;
            end else if (op == 1) begin
                f3    = func3_or;
                c_exp = c_a | c_b;
            end else begin
                f3    = func3_xor;
                c_exp = c_a ^ c_b;
            end
            run_op(op_name(f3, 1'b0, 1'b0, 1'b0), f3, 1'b0, 1'b0, 1'b0, c_a, c_b, c_exp);
        end

        @(negedge clk);
        $display("tests %0d passed %0d failed %0d", n_tests, n_tests - n_failed, n_failed);
        if (n_failed == 0 && n_errs == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // watchdog
    initial begin
        longint limit_ns;

        wait (loaded);
        limit_ns = longint'(vecs.size() + 20) * (word_len + 4) * clk_period;
        #(limit_ns);
        $display("timeout, the DUT stopped finishing operations before all tests ran");
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb_alu_input.txt ====
// columns in hex: func3 mode imm extension rs1 rs2 expected_rd
// extension 1 with func3 1xx is a divide, 0xx a multiply code
0 0 0 0 00000005 00000007 0000000c
0 0 0 0 ffffffff 00000002 00000001
0 1 0 0 00000005 00000007 fffffffe
0 1 1 0 00000005 00000007 0000000c
1 0 0 0 00000001 0000001f 80000000
1 0 0 0 00000003 00000024 00000030
5 0 0 0 80000000 00000004 08000000
5 1 0 0 80000000 00000004 f8000000
5 1 0 0 80000000 0000003f ffffffff
5 0 0 0 f0000000 00000021 78000000
4 0 0 0 ff00ff00 0f0f0f0f f00ff00f
6 0 0 0 ff00ff00 0f0f0f0f ff0fff0f
7 0 0 0 ff00ff00 0f0f0f0f 0f000f00
4 0 0 1 ffffffec 00000006 fffffffd
6 0 0 1 ffffffec 00000006 fffffffe
4 0 0 1 00000014 fffffffa fffffffd
6 0 0 1 00000014 fffffffa 00000002
5 0 0 1 ffffffec 00000006 2aaaaaa7
7 0 0 1 ffffffec 00000006 00000002
4 0 0 1 fffffff9 fffffffe 00000003
6 0 0 1 fffffff9 fffffffe ffffffff
4 0 0 1 00001234 00000000 ffffffff
5 0 0 1 fffffff0 00000000 ffffffff
6 0 0 1 fffffff9 00000000 fffffff9
7 0 0 1 00001234 00000000 00001234
4 0 0 1 80000000 ffffffff 80000000
0 0 0 1 00000003 00000004 00000000
3 0 0 1 12345678 9abcdef0 00000000
6 0 0 1 80000000 ffffffff 00000000
